/* hdl/vtl_pkg.sv */
// video/bus controller shared definitions
// geometry, bus slots, port map, types and palette
`default_nettype none

package vtl_pkg;

	// timing defaults, all in pixel clocks or lines
	localparam logic [9:0] HSW         = 10'd66;  // hsync width
	localparam logic [9:0] HBP         = 10'd78;  // back porch
	localparam logic [9:0] HFP         = 10'd10;  // front porch
	localparam logic [9:0] H_VISIBLE   = 10'd798; // border + active
	localparam logic [9:0] LEFT_BORDER = 10'd72;
	localparam logic [9:0] ACTIVE_W    = 10'd640;
	localparam logic [9:0] LINE_LEN    = 10'd952; // HSW+HBP+H_VISIBLE+HFP
	localparam logic [9:0] V_LINES     = 10'd312;
	localparam logic [9:0] TOP_BORDER  = 10'd64;
	localparam logic [9:0] ACTIVE_H    = 10'd192;
	localparam logic [9:0] VSYNC_LINES = 10'd2;

	// 8-clock bus schedule, slots 3..6 belong to the cpu
	localparam logic [2:0] SLOT_CPU_ENABLE  = 3'd2;
	localparam logic [2:0] SLOT_CPU_ACCESS  = 3'd3;
	localparam logic [2:0] SLOT_WRITE_END   = 3'd4;
	localparam logic [2:0] SLOT_VIDEO_START = 3'd7; // video address update
	localparam logic [2:0] SLOT_VIDEO_LATCH = 3'd0; // video byte capture

	localparam logic [7:0] PORT_BANK0  = 8'h40; // 0x40..0x43
	localparam logic [7:0] PORT_MODE   = 8'h44;
	localparam logic [7:0] PORT_COLORS = 8'h45;

	localparam logic [3:0]  MAPPED_IO_BANK = 4'd2;
	localparam logic [13:0] MAPPED_IO_LO   = 14'h2800;
	localparam logic [13:0] MAPPED_IO_HI   = 14'h2FFF;
	localparam logic [3:0]  RAM_BANK       = 4'd3;

	typedef logic [3:0]  color_t;    // palette index
	typedef logic [5:0]  rgb_t;      // one dac channel
	typedef logic [24:0] mem_addr_t;
	typedef enum logic {GR5 = 1'b0, GR3 = 1'b1} gr_mode_t;

	// 4 bits per channel, r in 11:8
	localparam logic [0:15][11:0] PALETTE = {
		12'h000, 12'h008, 12'h080, 12'h088,
		12'h800, 12'h088, 12'h880, 12'h888,
		12'h444, 12'h44f, 12'h4f4, 12'h4ff,
		12'hf44, 12'hf4f, 12'hff4, 12'hfff
	};

	localparam color_t BLANK_COLOR = 4'd12; // forced blank

endpackage

`default_nettype wire

/* hdl/vdc_regs_if.sv */
// video configuration from the cpu bus decoder to the fetch path
`timescale 1ns/100ps
`default_nettype none

interface vdc_regs_if import vtl_pkg::*; ();

	logic     gfx_enable; // mapped io bit 3
	gr_mode_t mode;
	logic     page_7;     // video ram in page 7, else page 3
	color_t   border;
	color_t   fg;
	color_t   bg;

	modport regs (output gfx_enable, mode, page_7, border, fg, bg);
	modport view (input gfx_enable, mode, page_7, border, fg, bg);

endinterface

`default_nettype wire

/* hdl/video_timing.sv */
// raster counters, sync and region flags
// also hands out the 8-clock bus slot
`timescale 1ns/100ps
`default_nettype none

module video_timing import vtl_pkg::*; #(
	parameter logic [9:0] HSW         = vtl_pkg::HSW,
	parameter logic [9:0] HBP         = vtl_pkg::HBP,
	parameter logic [9:0] HFP         = vtl_pkg::HFP,
	parameter logic [9:0] H_VISIBLE   = vtl_pkg::H_VISIBLE,
	parameter logic [9:0] LEFT_BORDER = vtl_pkg::LEFT_BORDER,
	parameter logic [9:0] ACTIVE_W    = vtl_pkg::ACTIVE_W,
	parameter logic [9:0] V_LINES     = vtl_pkg::V_LINES,
	parameter logic [9:0] TOP_BORDER  = vtl_pkg::TOP_BORDER,
	parameter logic [9:0] ACTIVE_H    = vtl_pkg::ACTIVE_H
) (
	input  logic       F14M,
	input  logic       RESET,
	output logic [2:0] slot,
	output logic [9:0] xcnt,             // column inside active area
	output logic [7:0] row,              // active area line
	output logic       line_start_fetch,
	output logic       blanking,
	output logic       border,
	output logic       hsync,
	output logic       vsync,
	output logic       cpuena
);

	localparam logic [9:0] H_VIS_START = HSW + HBP;
	localparam logic [9:0] H_ACT_START = H_VIS_START + LEFT_BORDER;
	localparam logic [9:0] H_VIS_END   = H_VIS_START + H_VISIBLE;
	localparam logic [9:0] H_LAST      = H_VIS_END + HFP - 10'd1;
	localparam logic [9:0] LOAD_COL    = H_ACT_START - 10'd9; // one byte early, slot 7

	logic [9:0] hcnt;
	logic [9:0] vcnt;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
			row  <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			vcnt <= (vcnt == V_LINES - 10'd1) ? 10'd0 : vcnt + 10'd1;
			// row 0 is the first line below the top border
			row  <= (vcnt == TOP_BORDER - 10'd1) ? 8'd0 : row + 8'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign slot = hcnt[2:0];
	assign xcnt = hcnt - H_ACT_START; // active start is 8-aligned
	assign cpuena = (slot == SLOT_CPU_ENABLE);
	assign line_start_fetch = (hcnt == LOAD_COL);

	assign hsync = !(hcnt < HSW);         // negative
	assign vsync = !(vcnt < VSYNC_LINES); // negative

	assign blanking = hcnt < H_VIS_START || hcnt >= H_VIS_END || vcnt < VSYNC_LINES;
	assign border = vcnt < TOP_BORDER || vcnt >= TOP_BORDER + ACTIVE_H
		|| hcnt < H_ACT_START || hcnt >= H_ACT_START + ACTIVE_W;

endmodule

`default_nettype wire

/* hdl/cpu_bus.sv */
// z80 bus decode: banking, mapped io, video ports
// and the shared byte-wide memory port
`timescale 1ns/100ps
`default_nettype none

module cpu_bus import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  logic [2:0]  slot,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  cpu_dout,
	input  logic [6:0]  kd,
	input  logic        cassette_in,
	input  logic [7:0]  mem_rdata,
	input  mem_addr_t   video_addr,
	output logic [7:0]  cpu_din,
	output mem_addr_t   mem_addr,
	output logic [7:0]  mem_wdata,
	output logic        mem_wr,
	output logic        mem_rd,
	output logic        buzzer,
	output logic        casout,
	vdc_regs_if.regs    vdc
);

	logic mreq, iorq, rd, wr;
	assign mreq = !mreq_n;
	assign iorq = !iorq_n;
	assign rd   = !rd_n;
	assign wr   = !wr_n;

	logic [3:0][3:0] banks;   // 16k page per cpu quarter
	logic [3:0]      bank;
	logic [13:0]     base;
	logic            bank_is_ram, mapped_io, access, cpu_slot;

	assign bank = banks[a[15:14]];
	assign base = a[13:0];
	assign bank_is_ram = (bank == RAM_BANK);
	assign mapped_io = bank == MAPPED_IO_BANK && base >= MAPPED_IO_LO && base <= MAPPED_IO_HI;
	assign access = (slot == SLOT_CPU_ACCESS);

	always_ff @(posedge F14M) begin
		if (RESET) begin
			banks          <= '0;
			mem_wr         <= 1'b0;
			mem_rd         <= 1'b0;
			buzzer         <= 1'b0;
			casout         <= 1'b0;
			vdc.gfx_enable <= 1'b0;
			vdc.mode       <= GR5;
			vdc.page_7     <= 1'b0;
			vdc.border     <= '0;
			vdc.fg         <= '0;
			vdc.bg         <= '0;
		end else begin
			mem_rd <= (slot != SLOT_CPU_ENABLE - 3'd1); // low through slot 2
			if (slot == SLOT_WRITE_END)
				mem_wr <= 1'b0;                    // one clock pulse
			if (access && mreq && wr) begin
				if (mapped_io) begin
					vdc.gfx_enable <= cpu_dout[3];
					casout         <= cpu_dout[2];
					buzzer         <= cpu_dout[0];
				end else begin
					mem_wr <= bank_is_ram;             // rom banks ignore writes
				end
			end
			if (access && iorq && wr) begin
				if (a[7:2] == PORT_BANK0[7:2]) begin
					banks[a[1:0]] <= cpu_dout[3:0];
				end else if (a[7:0] == PORT_MODE) begin
					vdc.page_7 <= !cpu_dout[3];
					vdc.mode   <= (cpu_dout[2:0] == 3'b011) ? GR3 : GR5; // rest falls to gr5
					vdc.border <= cpu_dout[7:4];
				end else if (a[7:0] == PORT_COLORS) begin
					vdc.fg <= cpu_dout[7:4];
					vdc.bg <= cpu_dout[3:0];
				end
			end
		end
	end

	// data paths
	always_ff @(posedge F14M) begin
		if (access && mreq && rd)
			cpu_din <= mapped_io ? {cassette_in, kd} : mem_rdata;
		if (access && mreq && wr)
			mem_wdata <= cpu_dout;
	end

	// cpu owns the address in slots 3..6
	assign cpu_slot = slot >= SLOT_CPU_ACCESS && slot < SLOT_VIDEO_START;
	assign mem_addr = cpu_slot ? {7'd0, bank, base} : video_addr;

endmodule

`default_nettype wire

/* hdl/video_fetch.sv */
// video ram address generator and pixel pipe
// gr5 1bpp and gr3 4bpp, with border and blank priority
`timescale 1ns/100ps
`default_nettype none

module video_fetch import vtl_pkg::*; (
	input  logic       F14M,
	input  logic       RESET,
	input  logic [2:0] slot,
	input  logic [9:0] xcnt,
	input  logic [7:0] row,
	input  logic       line_start_fetch,
	input  logic       blanking,
	input  logic       border,
	input  logic       blank,      // forced blank, e.g. during download
	input  logic [7:0] mem_rdata,
	output mem_addr_t  video_addr,
	output color_t     pixel,
	vdc_regs_if.view   vdc
);

	logic [13:0] vram_addr;
	logic [7:0]  byte_latch;
	logic [7:0]  shifter;
	logic [3:0]  page;

	// address update and byte capture
	always_ff @(posedge F14M) begin
		if (slot == SLOT_VIDEO_START) begin
			if (line_start_fetch)
				// interleaved rows, 80 bytes each
				vram_addr <= {row[2:0], row[5:3], row[7:6], row[7:6], 4'd0};
			else
				vram_addr <= vram_addr + 14'd1;
		end
		if (slot == SLOT_VIDEO_LATCH)
			byte_latch <= mem_rdata;
	end

	assign page = vdc.page_7 ? 4'h7 : 4'h3;
	assign video_addr = {7'd0, page, vram_addr};

	// shifter, reloaded on the last clock of each byte
	always_ff @(posedge F14M) begin
		if (xcnt[2:0] == 3'd7)
			shifter <= byte_latch;
		else if (vdc.mode == GR5)
			shifter <= shifter >> 1;   // lsb first
		else if (xcnt[1:0] == 2'd0)
			shifter <= shifter >> 4;   // low nibble first
	end

	always_ff @(posedge F14M) begin
		if (RESET)
			pixel <= '0;
		else if (blanking)
			pixel <= '0;
		else if (blank)
			pixel <= BLANK_COLOR;
		else if (border)
			pixel <= vdc.border;
		else if (!vdc.gfx_enable)
			pixel <= vdc.bg;              // graphics off shows background
		else if (vdc.mode == GR5)
			pixel <= shifter[0] ? vdc.fg : vdc.bg;
		else if (xcnt[1:0] == 2'd0)
			pixel <= shifter[3:0];        // gr3 holds for 4 clocks
	end

endmodule

`default_nettype wire

/* hdl/palette.sv */
// fixed 16-entry palette, index to 6-bit rgb
`timescale 1ns/100ps
`default_nettype none

module palette import vtl_pkg::*; (
	input  color_t pixel,
	output rgb_t   r,
	output rgb_t   g,
	output rgb_t   b
);

	logic [11:0] entry;

	assign entry = PALETTE[pixel];

	// 4-bit channels padded to the 6-bit dac
	assign r = {entry[11:8], 2'b00};
	assign g = {entry[7:4], 2'b00};
	assign b = {entry[3:0], 2'b00};

endmodule

`default_nettype wire

/* hdl/vtl_top.sv */
// video and bus controller top level
`timescale 1ns/100ps
`default_nettype none

module vtl_top import vtl_pkg::*; #(
	parameter logic [9:0] HSW         = vtl_pkg::HSW,
	parameter logic [9:0] HBP         = vtl_pkg::HBP,
	parameter logic [9:0] HFP         = vtl_pkg::HFP,
	parameter logic [9:0] H_VISIBLE   = vtl_pkg::H_VISIBLE,
	parameter logic [9:0] LEFT_BORDER = vtl_pkg::LEFT_BORDER,
	parameter logic [9:0] ACTIVE_W    = vtl_pkg::ACTIVE_W,
	parameter logic [9:0] V_LINES     = vtl_pkg::V_LINES,
	parameter logic [9:0] TOP_BORDER  = vtl_pkg::TOP_BORDER,
	parameter logic [9:0] ACTIVE_H    = vtl_pkg::ACTIVE_H
) (
	input  logic        F14M,        // pixel clock
	input  logic        RESET,
	input  logic        blank,
	output logic        cpuena,      // z80 clock enable
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  cpu_dout,
	output logic [7:0]  cpu_din,
	input  logic [6:0]  kd,          // keyboard row data
	input  logic        cassette_in,
	output mem_addr_t   mem_addr,
	input  logic [7:0]  mem_rdata,
	output logic [7:0]  mem_wdata,
	output logic        mem_wr,
	output logic        mem_rd,
	output logic        hsync,
	output logic        vsync,
	output rgb_t        r,
	output rgb_t        g,
	output rgb_t        b,
	output logic        buzzer,
	output logic        casout
);

	logic [2:0] slot;
	logic [9:0] xcnt;
	logic [7:0] row;
	logic       line_start_fetch, blanking, border;
	mem_addr_t  video_addr;
	color_t     pixel;

	vdc_regs_if vdc ();

	video_timing #(
		.HSW(HSW), .HBP(HBP), .HFP(HFP), .H_VISIBLE(H_VISIBLE),
		.LEFT_BORDER(LEFT_BORDER), .ACTIVE_W(ACTIVE_W), .V_LINES(V_LINES),
		.TOP_BORDER(TOP_BORDER), .ACTIVE_H(ACTIVE_H)
	) u_timing (
		.F14M(F14M), .RESET(RESET), .slot(slot), .xcnt(xcnt), .row(row),
		.line_start_fetch(line_start_fetch), .blanking(blanking), .border(border),
		.hsync(hsync), .vsync(vsync), .cpuena(cpuena)
	);

	cpu_bus u_bus (
		.F14M(F14M), .RESET(RESET), .slot(slot), .mreq_n(mreq_n), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .a(a), .cpu_dout(cpu_dout), .kd(kd),
		.cassette_in(cassette_in), .mem_rdata(mem_rdata), .video_addr(video_addr),
		.cpu_din(cpu_din), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wr(mem_wr),
		.mem_rd(mem_rd), .buzzer(buzzer), .casout(casout), .vdc(vdc.regs)
	);

	video_fetch u_fetch (
		.F14M(F14M), .RESET(RESET), .slot(slot), .xcnt(xcnt), .row(row),
		.line_start_fetch(line_start_fetch), .blanking(blanking), .border(border),
		.blank(blank), .mem_rdata(mem_rdata), .video_addr(video_addr), .pixel(pixel),
		.vdc(vdc.view)
	);

	palette u_palette (.pixel(pixel), .r(r), .g(g), .b(b));

endmodule

`default_nettype wire

/* test/tb_vtl_asserts.sv */
// bound checks on the bus slot schedule
// and the one-clock memory write strobe
`timescale 1ns/100ps
`default_nettype none

module tb_vtl_asserts import vtl_pkg::*; (
	input logic       F14M,
	input logic       RESET,
	input logic [2:0] slot,
	input logic       cpuena,
	input logic       mem_wr
);

	int fail_count = 0; // failed assertion count

	a_wr_single: assert property (@(posedge F14M) disable iff (RESET) mem_wr |=> !mem_wr)
		else begin
			fail_count++;
			$error("mem_wr stayed high for more than one clock");
		end

	// line length keeps the 8-clock schedule running across line ends
	a_cpuena_period: assert property (@(posedge F14M) disable iff (RESET)
		cpuena |=> !cpuena [*7] ##1 cpuena)
		else begin
			fail_count++;
			$error("cpuena not high exactly one clock in eight");
		end

	a_wr_slot: assert property (@(posedge F14M) disable iff (RESET)
		mem_wr |-> slot == SLOT_WRITE_END)
		else begin
			fail_count++;
			$error("mem_wr high outside the write slot");
		end

endmodule

bind vtl_top tb_vtl_asserts u_asserts (
	.F14M(F14M), .RESET(RESET), .slot(slot), .cpuena(cpuena), .mem_wr(mem_wr)
);

`default_nettype wire

/* test/tb_vtl.sv */
// testbench for the video and bus controller
// random z80 cycles against a memory model, raster checks on sync and pixels
`timescale 1ns/100ps
`default_nettype none

module tb_vtl import vtl_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int H_VIS0 = HSW + HBP;            // first visible clock of a line
	localparam int H_ACT0 = H_VIS0 + LEFT_BORDER; // first active clock
	// frames of test time: sync 1, border 1, three gr5 scans up to 2, gr3 1
	localparam int TEST_FRAMES = 8;
	localparam longint FRAME_NS = longint'(LINE_LEN) * V_LINES * CLK_PERIOD;
	localparam longint WATCHDOG_NS = FRAME_NS * TEST_FRAMES * 105 / 100;
	localparam int MAX_LINES = 8; // printed mismatches per test

	logic        F14M, RESET, blank, cpuena, mreq_n, iorq_n, rd_n, wr_n;
	logic [15:0] a;
	logic [7:0]  cpu_dout, cpu_din, mem_rdata, mem_wdata;
	logic [6:0]  kd;
	logic        cassette_in, mem_wr, mem_rd, hsync, vsync, buzzer, casout;
	mem_addr_t   mem_addr;
	rgb_t        r, g, b;

	logic [7:0]  mem [0:65535];  // 64k model, upper address bits fold
	logic [32:0] pulses [$];     // {addr, data} per mem_wr clock
	logic [31:0] rng_state = 32'd68340;
	logic [3:0]  tb_banks [4];   // expected bank registers
	int          errors, test_errors, tests_run, tests_failed, assert_fails;
	int          h, v;           // tracked raster position at each negedge
	string       test_name;

	vtl_top uut (.*);

	initial begin
		F14M = 1'b0;
		forever #(CLK_PERIOD / 2) F14M = ~F14M;
	end

	assign mem_rdata = mem[mem_addr[15:0]]; // asynchronous read
	always @(posedge F14M)
		if (mem_wr)
			mem[mem_addr[15:0]] <= mem_wdata;
	always @(negedge F14M)
		if (mem_wr)
			pulses.push_back({mem_addr, mem_wdata});

	function automatic logic [15:0] lcg();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	// palette entry, each channel padded with two zero bits
	function automatic logic [17:0] rgb_of(input color_t idx);
		logic [11:0] e;
		e = PALETTE[idx];
		return {e[11:8], 2'b00, e[7:4], 2'b00, e[3:0], 2'b00};
	endfunction

	function automatic logic in_window(input logic [3:0] bank, input logic [13:0] base);
		return bank == MAPPED_IO_BANK && base >= MAPPED_IO_LO && base <= MAPPED_IO_HI;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		test_errors++;
		if (test_errors <= MAX_LINES)
			$display("mismatch at %0d ns: %s", $time, msg);
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-10s %s, %0d errors", test_name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
	endtask

	// one z80 cycle, driven in slot 3 and released after slot 4
	task automatic bus_cycle(input logic io, input logic write, input logic [15:0] addr,
		input logic [7:0] data, output logic [7:0] din);
		@(negedge F14M);
		while (!cpuena)
			@(negedge F14M);
		if (mem_rd !== 1'b0)
			report_mismatch("mem_rd high in the cpu enable slot");
		@(posedge F14M);
		#2;
		a = addr;
		cpu_dout = data;
		mreq_n = io;
		iorq_n = !io;
		rd_n = write;
		wr_n = !write;
		@(negedge F14M); // slot 3
		if (mem_rd !== 1'b1)
			report_mismatch("mem_rd still low after the cpu enable slot");
		@(negedge F14M); // slot 4, after the access edge
		din = cpu_din;
		@(posedge F14M);
		#2;
		{mreq_n, iorq_n, rd_n, wr_n} = 4'hF;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		logic [7:0] din;
		bus_cycle(1'b1, 1'b1, {8'h00, port}, data, din);
	endtask

	task automatic step();
		@(negedge F14M);
		if (h == LINE_LEN - 1) begin
			h = 0;
			v = (v == V_LINES - 1) ? 0 : v + 1;
		end else begin
			h++;
		end
	endtask

	task automatic seek(input int line, input int col);
		while (h != col || v != line)
			step();
	endtask

	// vsync rises at clock 0 of the first line after sync
	task automatic find_frame();
		logic prev;
		@(negedge F14M);
		do begin
			prev = vsync;
			@(negedge F14M);
		end while (!(!prev && vsync));
		h = 0;
		v = VSYNC_LINES;
	endtask

	task automatic next_hsync_fall();
		logic prev;
		do begin
			prev = hsync;
			@(negedge F14M);
		end while (!(prev && !hsync));
	endtask

	// rgb at clock h shows the position h-1
	task automatic check_rgb(input logic [17:0] exp, input string what);
		if ({r, g, b} != exp)
			report_mismatch($sformatf("%s line %0d clock %0d rgb %h, expected %h",
				what, v, h, {r, g, b}, exp));
	endtask

	task automatic fill_vram(input logic [7:0] fill);
		for (int i = 'hC000; i <= 'hFFFF; i++)
			mem[i] = fill; // page 7 lands in the top 16k of the model
	endtask

	task automatic sync_timing();
		int low_cnt, len, vs_low;
		open_test("sync");
		next_hsync_fall();
		low_cnt = 1;
		len = 1;
		@(negedge F14M);
		while (hsync || len == 1 || low_cnt == len) begin // until the next fall
			len++;
			if (!hsync)
				low_cnt++;
			@(negedge F14M);
		end
		if (low_cnt != HSW)
			report_mismatch($sformatf("hsync low %0d clocks, expected %0d", low_cnt, HSW));
		if (len != LINE_LEN)
			report_mismatch($sformatf("line of %0d clocks, expected %0d", len, LINE_LEN));
		vs_low = 0;
		for (int i = 0; i < V_LINES; i++) begin
			if (!vsync)
				vs_low++;
			if (i < V_LINES - 1)
				next_hsync_fall();
		end
		if (vs_low != VSYNC_LINES)
			report_mismatch($sformatf("vsync low %0d lines, expected %0d", vs_low, VSYNC_LINES));
		close_test();
	endtask

	task automatic write_cycles();
		logic [15:0] addr, rv;
		logic [7:0]  data, din;
		logic [3:0]  bank;
		int          exp_cnt;
		open_test("mem_write");
		for (int round = 0; round < 4; round++) begin
			for (int i = 0; i < 4; i++) begin
				rv = lcg();
				tb_banks[i] = rv[4] ? RAM_BANK : rv[3:0]; // ram often enough
				io_write(PORT_BANK0 | 8'(i), {4'h0, tb_banks[i]});
			end
			for (int i = 0; i < 16; i++) begin
				addr = lcg();
				rv = lcg();
				data = rv[7:0];
				bank = tb_banks[addr[15:14]];
				exp_cnt = (bank == RAM_BANK) ? 1 : 0; // rom and mapped io give no strobe
				pulses.delete();
				bus_cycle(1'b0, 1'b1, addr, data, din);
				if (pulses.size() != exp_cnt)
					report_mismatch($sformatf("write bank %0d addr %h gave %0d strobes, expected %0d",
						bank, addr, pulses.size(), exp_cnt));
				else if (exp_cnt == 1 && pulses[0] != {7'd0, bank, addr[13:0], data})
					report_mismatch($sformatf("write strobe %h, expected %h", pulses[0],
						{7'd0, bank, addr[13:0], data}));
			end
		end
		close_test();
	endtask

	task automatic read_cycles();
		logic [15:0] addr, rv;
		logic [7:0]  exp, din, data;
		logic [3:0]  bank;
		open_test("mem_read");
		for (int i = 0; i < 24; i++) begin
			addr = lcg();
			rv = lcg();
			kd = rv[6:0];
			cassette_in = rv[7];
			bank = tb_banks[addr[15:14]];
			exp = in_window(bank, addr[13:0]) ? {cassette_in, kd} : mem[{bank[1:0], addr[13:0]}];
			bus_cycle(1'b0, 1'b0, addr, 8'h00, din);
			if (din !== exp)
				report_mismatch($sformatf("read %h bank %0d gave %h, expected %h",
					addr, bank, din, exp));
		end
		io_write(PORT_BANK0, {4'h0, MAPPED_IO_BANK});
		tb_banks[0] = MAPPED_IO_BANK;
		for (int i = 0; i < 8; i++) begin
			rv = lcg();
			addr = {2'b00, MAPPED_IO_LO | {3'b000, rv[10:0]}};
			kd = rv[6:0];
			cassette_in = rv[15];
			bus_cycle(1'b0, 1'b0, addr, 8'h00, din);
			if (din !== {cassette_in, kd})
				report_mismatch($sformatf("mapped read %h gave %h, expected %h",
					addr, din, {cassette_in, kd}));
			rv = lcg();
			data = rv[7:0];
			pulses.delete();
			bus_cycle(1'b0, 1'b1, addr, data, din);
			if (pulses.size() != 0)
				report_mismatch($sformatf("mapped write %h raised mem_wr", addr));
			if (buzzer !== data[0] || casout !== data[2])
				report_mismatch($sformatf("mapped write %h buzzer %b casout %b, expected %b %b",
					data, buzzer, casout, data[0], data[2]));
		end
		close_test();
	endtask

	task automatic border_colour();
		logic [15:0] rv;
		color_t      colour;
		open_test("border");
		rv = lcg();
		colour = rv[3:0];
		io_write(PORT_MODE, {colour, 4'b0000});
		find_frame();
		seek(VSYNC_LINES + 8, H_VIS0 + 1); // top border line
		while (h <= H_VIS0 + H_VISIBLE) begin
			check_rgb(rgb_of(colour), "border");
			step();
		end
		@(posedge F14M);
		#2 blank = 1'b1; // set in the horizontal blanking
		seek(VSYNC_LINES + 9, H_VIS0 + 1);
		while (h <= H_VIS0 + H_VISIBLE) begin
			check_rgb(rgb_of(BLANK_COLOR), "blank");
			step();
		end
		@(posedge F14M);
		#2 blank = 1'b0;
		close_test();
	endtask

	task automatic gr5_scan(input logic [7:0] fill, input color_t fg, input color_t bg);
		logic [17:0] px, prev;
		fill_vram(fill);
		find_frame();
		for (int row = 8; row <= 183; row++) begin
			seek(TOP_BORDER + row, H_ACT0 + 1 + 16);
			prev = '0;
			for (int col = 16; col <= 623; col++) begin
				px = {r, g, b};
				if (fill == 8'hFF)
					check_rgb(rgb_of(fg), "gr5 ones");
				else if (fill == 8'h00)
					check_rgb(rgb_of(bg), "gr5 zeros");
				else if ((px != rgb_of(fg) && px != rgb_of(bg)) || (col > 16 && px == prev))
					report_mismatch($sformatf("gr5 0xaa row %0d col %0d rgb %h not alternating",
						row, col, px));
				// slot 0 carries the video address
				if (h % 8 == 0 && mem_addr[24:14] !== 11'h007)
					report_mismatch($sformatf("video address %h outside page 7", mem_addr));
				prev = px;
				step();
			end
		end
	endtask

	task automatic gr5_content();
		logic [15:0] rv;
		logic [7:0]  din;
		color_t      fg, bg;
		open_test("gr5");
		rv = lcg();
		fg = rv[3:0];
		do begin
			rv = lcg();
			bg = rv[3:0];
		end while (rgb_of(bg) == rgb_of(fg)); // palette has a duplicate entry
		io_write(PORT_BANK0, {4'h0, MAPPED_IO_BANK});
		bus_cycle(1'b0, 1'b1, {2'b00, MAPPED_IO_LO}, 8'h08, din); // graphics on
		io_write(PORT_MODE, 8'h00);                                 // gr5, page 7
		io_write(PORT_COLORS, {fg, bg});
		gr5_scan(8'hFF, fg, bg);
		gr5_scan(8'h00, fg, bg);
		gr5_scan(8'hAA, fg, bg);
		close_test();
	endtask

	task automatic gr3_content();
		logic [15:0] rv;
		logic [7:0]  fill;
		logic [17:0] px, prev;
		int          run;
		open_test("gr3");
		do begin
			rv = lcg();
			fill = rv[7:0];
		end while (rgb_of(fill[3:0]) == rgb_of(fill[7:4]));
		io_write(PORT_MODE, 8'h03);
		fill_vram(fill);
		find_frame();
		for (int row = 8; row <= 183; row++) begin
			seek(TOP_BORDER + row, H_ACT0 + 1 + 16);
			prev = '0;
			run = 0;
			for (int col = 16; col <= 623; col++) begin
				px = {r, g, b};
				if (px != rgb_of(fill[3:0]) && px != rgb_of(fill[7:4]))
					report_mismatch($sformatf("gr3 row %0d col %0d rgb %h not from byte %h",
						row, col, px, fill));
				else if (col > 16 && (px == prev ? run == 4 : run != 4))
					report_mismatch($sformatf("gr3 row %0d col %0d run of %0d clocks",
						row, col, run));
				run = (col == 16 || px != prev) ? 1 : run + 1;
				prev = px;
				step();
			end
		end
		close_test();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, run not finished after %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		RESET = 1'b1;
		blank = 1'b0;
		{mreq_n, iorq_n, rd_n, wr_n} = 4'hF;
		a = '0;
		cpu_dout = '0;
		kd = '0;
		cassette_in = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		repeat (4) @(posedge F14M);
		#2 RESET = 1'b0;
		sync_timing();
		write_cycles();
		read_cycles();
		border_colour();
		gr5_content();
		gr3_content();
		assert_fails = uut.u_asserts.fail_count;
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, assert_fails);
		if (errors == 0 && tests_failed == 0 && assert_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/vtl_pkg.sv
hdl/vdc_regs_if.sv
hdl/video_timing.sv
hdl/cpu_bus.sv
hdl/video_fetch.sv
hdl/palette.sv
hdl/vtl_top.sv
test/tb_vtl_asserts.sv
test/tb_vtl.sv
